//--- cpu_pkg.sv
// Shared definitions for the four-stage MIPS-subset core.
// Holds the datapath widths, the reset fetch address, the opcode and ALU
// encodings and the records passed between pipeline stages.
// Every core module imports it inside its body.

`default_nettype none

package cpu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = 32'hbfc0_0000;  // boot vector

    // primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f
    } opcode_e;

    // R-type function field, instr[5:0]
    typedef enum logic [5:0] {
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_slt  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_lui,
        alu_pass    // operand b straight through
    } alu_op_e;

    typedef enum logic [1:0] {
        br_none,
        br_beq,
        br_bne,
        br_jump
    } branch_e;

    // fetch to decode
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
    } if_id_t;

    // decode to execute
    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        alu_op_e               alu_op;
        branch_e               branch;
        logic [xlen-1:0]       op_a;
        logic [xlen-1:0]       op_b;
        logic [xlen-1:0]       cmp_val;  // rt for beq/bne
        logic [xlen-1:0]       target;   // taken branch or jump address
        logic [reg_addr_w-1:0] dst;
        logic                  wr;
    } id_ex_t;

    // writeback and bypass record
    typedef struct packed {
        logic                  valid;
        logic                  wr;
        logic [reg_addr_w-1:0] dst;
        logic [xlen-1:0]       data;
        logic [xlen-1:0]       pc;
    } result_t;

endpackage

`default_nettype wire

//--- reg_file.sv
// General register file, 32 entries of 32 bits.
// Two asynchronous read ports and one write port fed by the writeback
// record. Register 0 reads as zero and is never written.

`default_nettype none

module reg_file (
    input  logic              aclk,
    input  logic [4:0]        ra,
    input  logic [4:0]        rb,
    output logic [31:0]       rdata_a,
    output logic [31:0]       rdata_b,
    input  cpu_pkg::result_t  wr
);
    import cpu_pkg::*;

    logic [xlen-1:0] regs [32];
    logic            we;

    assign we = wr.valid && wr.wr && (wr.dst != '0);

    always_ff @(posedge aclk) begin
        if (we)
            regs[wr.dst] <= wr.data;
    end

    assign rdata_a = (ra == '0) ? '0 : regs[ra];  // $zero
    assign rdata_b = (rb == '0) ? '0 : regs[rb];

endmodule

`default_nettype wire

//--- fetch_unit.sv
// Instruction fetch for the MIPS-subset core.
// Runs a read-only Wishbone classic master, one word per bus cycle, with
// one idle cycle between cycles. Kept words go to decode one at a time.
// A taken branch from execute reloads the PC; a word that was already
// requested when the redirect came is fetched and dropped.

`default_nettype none

module fetch_unit (
    input  logic             aclk,
    input  logic             rst,
    input  logic             redirect,
    input  logic [31:0]      redirect_pc,
    input  logic [31:0]      ibus_dat,
    input  logic             ibus_ack,
    output logic [31:0]      ibus_adr,
    output logic             ibus_cyc,
    output logic             ibus_stb,
    output cpu_pkg::if_id_t  if_id
);
    import cpu_pkg::*;

    logic [xlen-1:0] pc;         // next address to request
    logic [xlen-1:0] adr_q;      // address of the open bus cycle
    logic            busy;       // cyc/stb
    logic            discard;    // open cycle is on the wrong path
    logic            keep;
    logic            out_valid;
    logic [xlen-1:0] out_pc;
    logic [xlen-1:0] out_instr;

    // word arrives and is still wanted
    assign keep = busy && ibus_ack && !discard && !redirect;

    always_ff @(posedge aclk) begin
        if (rst) begin
            pc        <= reset_pc;
            busy      <= 1'b0;
            discard   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= keep;

            if (redirect)
                pc <= redirect_pc;
            else if (keep)
                pc <= adr_q + 32'd4;

            if (!busy) begin
                busy <= 1'b1;       // idle lasts exactly one cycle
            end else if (ibus_ack) begin
                busy    <= 1'b0;    // word done, kept or dropped
                discard <= 1'b0;
            end else if (redirect) begin
                discard <= 1'b1;    // wait out the cycle, then refetch
            end
        end
    end

    // address latched at request start, held until ack
    always_ff @(posedge aclk) begin
        if (!busy)
            adr_q <= redirect ? redirect_pc : pc;
        if (keep) begin
            out_pc    <= adr_q;
            out_instr <= ibus_dat;
        end
    end

    assign ibus_adr = adr_q;
    assign ibus_cyc = busy;
    assign ibus_stb = busy;

    assign if_id = '{valid: out_valid, pc: out_pc, instr: out_instr};

endmodule

`default_nettype wire

//--- decode_stage.sv
// Decode stage.
// Splits the fetched word into fields, maps opcode and funct to an ALU
// operation and branch kind, reads rs/rt with bypass from execute and
// writeback, precomputes the branch or jump target and registers the
// result for execute. A redirect turns the next id_ex into a bubble.

`default_nettype none

module decode_stage (
    input  logic              aclk,
    input  logic              rst,
    input  cpu_pkg::if_id_t   if_id,
    input  logic              redirect,
    input  cpu_pkg::result_t  ex_fwd,
    input  cpu_pkg::result_t  wb,
    output cpu_pkg::id_ex_t   id_ex
);
    import cpu_pkg::*;

    opcode_e               opcode;
    funct_e                funct;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [reg_addr_w-1:0] rd;
    logic [15:0]           imm;
    logic [25:0]           index;
    logic [xlen-1:0]       rf_a;
    logic [xlen-1:0]       rf_b;
    logic [xlen-1:0]       rs_val;
    logic [xlen-1:0]       rt_val;
    logic [xlen-1:0]       imm_ext;
    logic [xlen-1:0]       pc_plus4;
    logic                  use_imm;
    logic                  zero_ext;
    id_ex_t                dec;
    id_ex_t                ex_q;
    logic                  valid_q;

    // youngest producer wins, $zero never bypassed
    function automatic logic [xlen-1:0] bypass(
        input logic [reg_addr_w-1:0] addr,
        input logic [xlen-1:0]       rf_val,
        input result_t               ex,
        input result_t               w
    );
        if (addr == '0)
            return '0;
        if (ex.valid && ex.wr && ex.dst == addr)
            return ex.data;
        if (w.valid && w.wr && w.dst == addr)
            return w.data;
        return rf_val;
    endfunction

    assign opcode   = opcode_e'(if_id.instr[31:26]);
    assign rs       = if_id.instr[25:21];
    assign rt       = if_id.instr[20:16];
    assign rd       = if_id.instr[15:11];
    assign imm      = if_id.instr[15:0];
    assign funct    = funct_e'(if_id.instr[5:0]);
    assign index    = if_id.instr[25:0];
    assign pc_plus4 = if_id.pc + 32'd4;

    reg_file u_reg_file (
        .aclk    (aclk),
        .ra      (rs),
        .rb      (rt),
        .rdata_a (rf_a),
        .rdata_b (rf_b),
        .wr      (wb)
    );

    assign rs_val = bypass(rs, rf_a, ex_fwd, wb);
    assign rt_val = bypass(rt, rf_b, ex_fwd, wb);

    always_comb begin
        dec.valid  = if_id.valid;
        dec.pc     = if_id.pc;
        dec.alu_op = alu_pass;
        dec.branch = br_none;
        dec.dst    = rt;           // I-type default
        dec.wr     = 1'b0;
        use_imm    = 1'b0;
        zero_ext   = 1'b0;

        case (opcode)
            op_special: begin
                dec.dst = rd;
                dec.wr  = 1'b1;
                case (funct)
                    fn_addu: dec.alu_op = alu_add;
                    fn_subu: dec.alu_op = alu_sub;
                    fn_and:  dec.alu_op = alu_and;
                    fn_or:   dec.alu_op = alu_or;
                    fn_xor:  dec.alu_op = alu_xor;
                    fn_slt:  dec.alu_op = alu_slt;
                    default: dec.wr     = 1'b0;  // sll nop and the rest
                endcase
            end
            op_addiu: begin
                dec.alu_op = alu_add;
                dec.wr     = 1'b1;
                use_imm    = 1'b1;
            end
            op_ori: begin
                dec.alu_op = alu_or;
                dec.wr     = 1'b1;
                use_imm    = 1'b1;
                zero_ext   = 1'b1;
            end
            op_lui: begin
                dec.alu_op = alu_lui;
                dec.wr     = 1'b1;
                use_imm    = 1'b1;
            end
            op_beq:  dec.branch = br_beq;
            op_bne:  dec.branch = br_bne;
            op_j:    dec.branch = br_jump;
            default: ;                           // outside the subset
        endcase

        imm_ext     = zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};
        dec.op_a    = rs_val;
        dec.op_b    = use_imm ? imm_ext : rt_val;
        dec.cmp_val = rt_val;

        // no delay slot, offsets are relative to pc+4
        if (dec.branch == br_jump)
            dec.target = {pc_plus4[31:28], index, 2'b00};
        else
            dec.target = pc_plus4 + {imm_ext[29:0], 2'b00};
    end

    always_ff @(posedge aclk) begin
        if (rst)
            valid_q <= 1'b0;
        else
            valid_q <= if_id.valid && !redirect;  // squash on taken branch
    end

    always_ff @(posedge aclk) begin
        ex_q <= dec;
    end

    always_comb begin
        id_ex       = ex_q;
        id_ex.valid = valid_q;
    end

endmodule

`default_nettype wire

//--- execute_stage.sv
// Execute and writeback for the MIPS-subset core.
// Runs the ALU, resolves beq/bne/j and signals a redirect for one cycle
// when taken. The result goes back to decode unregistered as ex_fwd and
// registered as wb, which also feeds the register file write port and
// the golden-trace debug outputs.

`default_nettype none

module execute_stage (
    input  logic              aclk,
    input  logic              rst,
    input  cpu_pkg::id_ex_t   id_ex,
    output cpu_pkg::result_t  ex_fwd,
    output cpu_pkg::result_t  wb,
    output logic              redirect,
    output logic [31:0]       redirect_pc,
    output logic [31:0]       debug_wb_pc,
    output logic [31:0]       debug_wb_rf_wdata,
    output logic [3:0]        debug_wb_rf_wen,
    output logic [4:0]        debug_wb_rf_wnum
);
    import cpu_pkg::*;

    logic [xlen-1:0] alu_res;
    logic            taken;
    result_t         wb_q;
    logic            wb_valid;

    always_comb begin
        alu_res = id_ex.op_b;
        case (id_ex.alu_op)
            alu_add:  alu_res = id_ex.op_a + id_ex.op_b;
            alu_sub:  alu_res = id_ex.op_a - id_ex.op_b;
            alu_and:  alu_res = id_ex.op_a & id_ex.op_b;
            alu_or:   alu_res = id_ex.op_a | id_ex.op_b;
            alu_xor:  alu_res = id_ex.op_a ^ id_ex.op_b;
            alu_slt:  alu_res = {31'd0, $signed(id_ex.op_a) < $signed(id_ex.op_b)};
            alu_lui:  alu_res = {id_ex.op_b[15:0], 16'h0000};
            alu_pass: alu_res = id_ex.op_b;
        endcase
    end

    always_comb begin
        case (id_ex.branch)
            br_beq:  taken = (id_ex.op_a == id_ex.cmp_val);
            br_bne:  taken = (id_ex.op_a != id_ex.cmp_val);
            br_jump: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // bubbles never redirect
    assign redirect    = id_ex.valid && taken;
    assign redirect_pc = id_ex.target;

    assign ex_fwd = '{valid: id_ex.valid,
                      wr:    id_ex.wr,
                      dst:   id_ex.dst,
                      data:  alu_res,
                      pc:    id_ex.pc};

    always_ff @(posedge aclk) begin
        if (rst)
            wb_valid <= 1'b0;
        else
            wb_valid <= id_ex.valid;   // execute always accepts
    end

    always_ff @(posedge aclk) begin
        wb_q <= ex_fwd;
    end

    always_comb begin
        wb       = wb_q;
        wb.valid = wb_valid;
    end

    // golden trace
    assign debug_wb_pc       = wb.pc;
    assign debug_wb_rf_wdata = wb.data;
    assign debug_wb_rf_wnum  = wb.dst;
    assign debug_wb_rf_wen   = (wb.valid && wb.wr && wb.dst != '0) ? 4'b1111 : 4'b0000;

endmodule

`default_nettype wire

//--- mips_core.sv
// Top level of the four-stage MIPS-subset core.
// Connects fetch, decode and execute to each other, to the read-only
// Wishbone instruction bus and to the golden-trace debug outputs.
// Fetch wait states are the only stall; later stages always accept.

`default_nettype none

module mips_core (
    input  logic        aclk,
    input  logic        rst,
    input  logic [31:0] ibus_dat,
    input  logic        ibus_ack,
    output logic [31:0] ibus_adr,
    output logic        ibus_cyc,
    output logic        ibus_stb,
    output logic [31:0] debug_wb_pc,
    output logic [31:0] debug_wb_rf_wdata,
    output logic [3:0]  debug_wb_rf_wen,
    output logic [4:0]  debug_wb_rf_wnum
);
    import cpu_pkg::*;

    if_id_t          if_id;
    id_ex_t          id_ex;
    result_t         ex_fwd;         // result of the instruction in execute
    result_t         wb;             // registered result, also rf write port
    logic            redirect;       // taken branch or jump
    logic [xlen-1:0] redirect_pc;

    fetch_unit u_fetch_unit (
        .aclk        (aclk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ibus_dat    (ibus_dat),
        .ibus_ack    (ibus_ack),
        .ibus_adr    (ibus_adr),
        .ibus_cyc    (ibus_cyc),
        .ibus_stb    (ibus_stb),
        .if_id       (if_id)
    );

    decode_stage u_decode_stage (
        .aclk     (aclk),
        .rst      (rst),
        .if_id    (if_id),
        .redirect (redirect),
        .ex_fwd   (ex_fwd),
        .wb       (wb),
        .id_ex    (id_ex)
    );

    execute_stage u_execute_stage (
        .aclk              (aclk),
        .rst               (rst),
        .id_ex             (id_ex),
        .ex_fwd            (ex_fwd),
        .wb                (wb),
        .redirect          (redirect),
        .redirect_pc       (redirect_pc),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// Clock and reset source for the core testbench.
// 20 ns clock; rst is high from time zero and drops on the 10th rising edge.

`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period  = 10;
    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;    // released on an edge like any other input
    end

endmodule

`default_nettype wire

//--- tb_mips_core.sv
// Testbench for the MIPS-subset core.
// Builds a program at time zero, serves it through a Wishbone slave model
// with random wait states, and checks the golden trace write by write
// against an instruction-set model of the same program.
// Also watches the instruction bus for protocol errors.

`default_nettype none

module tb_mips_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] boot_pc   = 32'hbfc0_0000;
    localparam int          mem_words = 512;
    localparam int          n_random  = 200;
    localparam int          max_wait  = 40000;   // cycles for the whole program
    localparam int          n_waits   = 1024;    // wait-state table, reused in a ring

    localparam logic [5:0] opc_special = 6'h00;
    localparam logic [5:0] opc_j       = 6'h02;
    localparam logic [5:0] opc_beq     = 6'h04;
    localparam logic [5:0] opc_bne     = 6'h05;
    localparam logic [5:0] opc_addiu   = 6'h09;
    localparam logic [5:0] opc_ori     = 6'h0d;
    localparam logic [5:0] opc_lui     = 6'h0f;

    logic        clk;
    logic        rst;
    logic [31:0] ibus_dat;
    logic        ibus_ack;
    logic [31:0] ibus_adr;
    logic        ibus_cyc;
    logic        ibus_stb;
    logic [31:0] debug_wb_pc;
    logic [31:0] debug_wb_rf_wdata;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;

    logic [31:0] prog [mem_words];
    int          prog_len = 0;
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_num [$];
    logic [31:0] exp_data [$];
    int          n_exp = 0;
    int          seen = 0;           // writes matched so far

    logic [1:0]  wait_tab [n_waits];
    int          wait_idx = 0;
    logic        bus_active = 1'b0;  // slave has picked its wait count
    int          waits_left = 0;
    logic        in_cycle = 1'b0;
    logic        first_seen = 1'b0;
    logic        ack_seen = 1'b0;
    logic [31:0] req_adr;

    tb_clock_gen u_tb_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    mips_core u_mips_core (
        .aclk              (clk),
        .rst               (rst),
        .ibus_dat          (ibus_dat),
        .ibus_ack          (ibus_ack),
        .ibus_adr          (ibus_adr),
        .ibus_cyc          (ibus_cyc),
        .ibus_stb          (ibus_stb),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            stop_run($sformatf("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp));
    endtask

    function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd);
        return {opc_special, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // jump to program word idx
    function automatic logic [31:0] enc_j(input int idx);
        logic [31:0] target;
        target = boot_pc + (idx << 2);
        return {opc_j, target[27:2]};
    endfunction

    function automatic logic [5:0] funct_of(input int k);
        case (k)
            0:       return 6'h21;  // addu
            1:       return 6'h23;  // subu
            2:       return 6'h24;  // and
            3:       return 6'h25;  // or
            4:       return 6'h26;  // xor
            default: return 6'h2a;  // slt
        endcase
    endfunction

    // unused space reads as opcode 3f, which the core ignores
    function automatic logic [31:0] read_word(input logic [31:0] adr);
        logic [31:0] off;
        off = adr - boot_pc;
        if (adr >= boot_pc && off[31:2] < prog_len)
            return prog[off[31:2]];
        return {6'h3f, adr[31:6] ^ adr[25:0]};
    endfunction

    task automatic put(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    task automatic build_program;
        int          r;
        int          i;
        int          k;
        int          kind;
        int          last;
        int          span;
        logic [31:0] rnd;
        logic [31:0] off;
        logic [31:0] imm32;
        for (r = 1; r < 32; r++) begin
            imm32 = r * 32'h0000_0b1d;
            put(enc_i(opc_addiu, 5'd0, r[4:0], imm32[15:0]));   // every register known
        end
        // directed block
        put(enc_i(opc_lui, 5'd0, 5'd1, 16'h1234));
        put(enc_i(opc_ori, 5'd1, 5'd1, 16'h5678));        // reads r1 just written by lui
        put(enc_i(opc_addiu, 5'd0, 5'd2, 16'hffff));
        put(enc_r(6'h21, 5'd1, 5'd2, 5'd3));
        put(enc_r(6'h23, 5'd3, 5'd1, 5'd4));
        put(enc_r(6'h24, 5'd4, 5'd1, 5'd5));
        put(enc_r(6'h25, 5'd5, 5'd2, 5'd6));
        put(enc_r(6'h26, 5'd6, 5'd1, 5'd7));
        put(enc_r(6'h2a, 5'd2, 5'd1, 5'd8));              // -1 < positive
        put(enc_r(6'h2a, 5'd1, 5'd2, 5'd9));
        put(enc_i(opc_addiu, 5'd1, 5'd0, 16'h0005));      // writes r0 and leaves no trace
        put(enc_r(6'h21, 5'd0, 5'd1, 5'd10));
        put(enc_i(opc_ori, 5'd0, 5'd0, 16'hffff));
        put(enc_r(6'h25, 5'd0, 5'd0, 5'd11));
        put(enc_i(opc_beq, 5'd1, 5'd1, 16'd1));           // taken
        put(enc_i(opc_addiu, 5'd0, 5'd12, 16'h0111));
        put(enc_i(opc_bne, 5'd1, 5'd1, 16'd1));           // not taken
        put(enc_i(opc_addiu, 5'd0, 5'd13, 16'h0222));
        put(enc_i(opc_beq, 5'd1, 5'd2, 16'd1));
        put(enc_i(opc_addiu, 5'd0, 5'd14, 16'h0333));
        put(enc_i(opc_bne, 5'd1, 5'd2, 16'd2));           // skips two
        put(enc_i(opc_addiu, 5'd0, 5'd15, 16'h0444));
        put(enc_i(opc_addiu, 5'd0, 5'd16, 16'h0555));
        put(enc_j(prog_len + 2));
        put(enc_i(opc_addiu, 5'd0, 5'd17, 16'h0666));
        put(32'h0000_0000);
        put(enc_i(6'h23, 5'd0, 5'd18, 16'h0010));         // lw is outside the subset
        put(enc_i(opc_addiu, 5'd18, 5'd18, 16'h0001));
        // random block where branches only go forward
        last = prog_len + n_random;
        for (k = 0; k < n_random; k++) begin
            i    = prog_len;
            kind = $urandom % 13;
            rnd  = $urandom;
            span = last - i - 1;
            if (span > 7)
                span = 7;
            off = $urandom % (span + 1);
            case (kind)
                0, 1, 2, 3, 4, 5:
                    put(enc_r(funct_of(kind), rnd[4:0], rnd[9:5], rnd[14:10]));
                6:  put(enc_i(opc_addiu, rnd[4:0], rnd[9:5], rnd[31:16]));
                7:  put(enc_i(opc_ori, rnd[4:0], rnd[9:5], rnd[31:16]));
                8:  put(enc_i(opc_lui, 5'd0, rnd[9:5], rnd[31:16]));
                9:  put(enc_i(opc_beq, rnd[4:0], rnd[15] ? rnd[4:0] : rnd[9:5], off[15:0]));
                10: put(enc_i(opc_bne, rnd[4:0], rnd[15] ? rnd[4:0] : rnd[9:5], off[15:0]));
                11: put(rnd[16] ? 32'h0000_0000 : {6'h3f, rnd[25:0]});
                default: put(enc_j(i + 1 + off));
            endcase
        end
        put(enc_j(prog_len));   // park here
    endtask

    // instruction-set model that returns the number of expected writes
    function automatic int build_expected();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] pc4;
        logic [31:0] nxt;
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sx;
        logic [31:0] res;
        logic [4:0]  dst;
        logic        wr;
        int          idx;
        int          steps;
        for (idx = 0; idx < 32; idx++)
            regs[idx] = 32'd0;
        pc = boot_pc;
        for (steps = 0; steps < 100000; steps++) begin
            idx = (pc - boot_pc) >> 2;
            if (idx >= prog_len)
                return -1;
            instr = prog[idx];
            pc4   = pc + 32'd4;
            nxt   = pc4;
            a     = regs[instr[25:21]];
            b     = regs[instr[20:16]];
            sx    = {{16{instr[15]}}, instr[15:0]};
            dst   = instr[20:16];
            wr    = 1'b0;
            res   = 32'd0;
            case (instr[31:26])
                opc_special: begin
                    dst = instr[15:11];
                    wr  = 1'b1;
                    case (instr[5:0])
                        6'h21:   res = a + b;
                        6'h23:   res = a - b;
                        6'h24:   res = a & b;
                        6'h25:   res = a | b;
                        6'h26:   res = a ^ b;
                        6'h2a:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                opc_j: begin
                    nxt = {pc4[31:28], instr[25:0], 2'b00};
                    if (nxt == pc)
                        return exp_pc.size();
                end
                opc_beq: if (a == b) nxt = pc4 + (sx << 2);
                opc_bne: if (a != b) nxt = pc4 + (sx << 2);
                opc_addiu: begin
                    wr  = 1'b1;
                    res = a + sx;
                end
                opc_ori: begin
                    wr  = 1'b1;
                    res = a | {16'h0000, instr[15:0]};
                end
                opc_lui: begin
                    wr  = 1'b1;
                    res = {instr[15:0], 16'h0000};
                end
                default: ;
            endcase
            if (wr && dst != 5'd0) begin
                regs[dst] = res;
                exp_pc.push_back(pc);
                exp_num.push_back(dst);
                exp_data.push_back(res);
            end
            pc = nxt;
        end
        return -1;
    endfunction

    // Wishbone slave with 0 to 3 wait states per cycle
    always @(posedge clk) begin
        if (rst) begin
            ibus_ack   <= 1'b0;
            bus_active = 1'b0;
        end else if (ibus_ack) begin
            ibus_ack <= 1'b0;
        end else if (ibus_cyc && ibus_stb) begin
            if (!bus_active) begin
                bus_active = 1'b1;
                waits_left = wait_tab[wait_idx % n_waits];
                wait_idx++;
            end
            if (waits_left == 0) begin
                ibus_ack   <= 1'b1;
                ibus_dat   <= read_word(ibus_adr);
                bus_active = 1'b0;
            end else begin
                waits_left--;
            end
        end
    end

    // bus protocol monitor
    always @(posedge clk) begin
        if (rst) begin
            in_cycle = 1'b0;
            ack_seen = 1'b0;
        end else begin
            check_equal("ibus_stb", ibus_stb, ibus_cyc);
            if (ack_seen && ibus_cyc)
                stop_run("ibus_cyc stayed high in the cycle right after ack");
            if (ibus_cyc && !in_cycle) begin
                in_cycle = 1'b1;
                req_adr  = ibus_adr;
                check_equal("ibus_adr[1:0]", {30'd0, ibus_adr[1:0]}, 32'd0);
                if (!first_seen)
                    check_equal("ibus_adr", ibus_adr, boot_pc);  // first request
                first_seen = 1'b1;
            end else if (ibus_cyc) begin
                check_equal("ibus_adr", ibus_adr, req_adr);
            end
            ack_seen = ibus_ack && ibus_cyc;
            if (ack_seen)
                in_cycle = 1'b0;
        end
    end

    // trace compare
    always @(posedge clk) begin
        if (!rst && debug_wb_rf_wen !== 4'h0) begin
            if (seen >= n_exp) begin
                stop_run("the core retired a register write past the end of the program");
            end else begin
                check_equal("debug_wb_rf_wen", {28'd0, debug_wb_rf_wen}, 32'h0000_000f);
                check_equal("debug_wb_pc", debug_wb_pc, exp_pc[seen]);
                check_equal("debug_wb_rf_wnum", {27'd0, debug_wb_rf_wnum},
                            {27'd0, exp_num[seen]});
                check_equal("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_data[seen]);
                seen++;
            end
        end
    end

    initial begin
        int cycles;
        int seed_out;
        int w;
        ibus_ack = 1'b0;
        ibus_dat = 32'd0;
        seed_out = $urandom(32'h234b);
        build_program();
        for (w = 0; w < n_waits; w++)
            wait_tab[w] = $urandom % 4;
        n_exp = build_expected();
        if (n_exp <= 0)
            stop_run("the reference model never reached the final jump");
        $display("program of %0d words, %0d expected writes", prog_len, n_exp);

        // reset and the first cycle after it
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 20)
                stop_run("timeout waiting for reset to be released");
            check_equal("ibus_cyc", ibus_cyc, 32'd0);
            check_equal("ibus_stb", ibus_stb, 32'd0);
            check_equal("debug_wb_rf_wen", {28'd0, debug_wb_rf_wen}, 32'd0);
        end while (rst);

        cycles = 0;
        while (seen < n_exp) begin
            @(negedge clk);
            cycles++;
            if (cycles > max_wait)
                stop_run("timeout waiting for the expected register writes");
        end
        repeat (100) @(negedge clk);   // core is parked so any stray write gets caught
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- mips_core.f
cpu_pkg.sv
reg_file.sv
fetch_unit.sv
decode_stage.sv
execute_stage.sv
mips_core.sv
tb_clock_gen.sv
tb_mips_core.sv
